// ==== logic/synthPkg.sv ====
// Shared types, widths and the semitone step function of the
// triangle synthesizer
package synthPkg;

    // --------------------
    // MIDI data widths
    // --------------------
    localparam int NOTE_W = 7;
    localparam int VEL_W = 7;

    // Sample and phase step width
    localparam int SAMPLE_W = 18;

    // Triangle reflection magnitude
    localparam int TRI_LIMIT = 65536;

    // Highest note with its own step, notes above reuse it
    localparam logic [NOTE_W-1:0] NOTE_TOP = 7'd99;

    // --------------------
    // Types
    // --------------------
    typedef enum logic [3:0] {
        CmdNoteOff = 4'h8,
        CmdNoteOn  = 4'h9
    } midiCmdE;

    typedef logic signed [SAMPLE_W-1:0] sampleT;

    // --------------------
    // Pitch table
    // --------------------
    // Octave 0 steps, one per semitone
    localparam logic [7:0] BASE_STEP [12] = '{
        8'h59, 8'h5E, 8'h64, 8'h6A,
        8'h70, 8'h77, 8'h7E, 8'h85,
        8'h8D, 8'h96, 8'h9F, 8'hA8
    };

    // Base step of the semitone, shifted up by the octave
    function automatic logic [SAMPLE_W-1:0] noteStep(input logic [NOTE_W-1:0] note);
        logic [NOTE_W-1:0] clamped;
        logic [3:0] octave;
        logic [3:0] semi;
        logic [SAMPLE_W-1:0] base;

        clamped = (note > NOTE_TOP) ? NOTE_TOP : note;
        octave = 4'(clamped / 7'd12);
        semi = 4'(clamped % 7'd12);
        base = SAMPLE_W'(BASE_STEP[semi]);
        return base << octave;
    endfunction

endpackage

// ==== logic/noteIf.sv ====
// Per-voice note command channel from the allocator to one voice
`timescale 1ns/1ps

interface noteIf import synthPkg::*; ();

    // One-cycle strobes, never high together
    logic start;
    logic stop;

    // Valid only while start is high
    logic [NOTE_W-1:0] note;
    logic [VEL_W-1:0] velocity;

    // Voice is playing
    logic active;

    modport alloc (
        output start, stop, note, velocity,
        input  active
    );

    modport voice (
        input  start, stop, note, velocity,
        output active
    );

endinterface

// ==== logic/midiVoiceAlloc.sv ====
// MIDI note command decoder and voice allocator
`timescale 1ns/1ps

module midiVoiceAlloc
    import synthPkg::*;
#(
    parameter int NUM_VOICES = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  midiValid,
    input  logic [3:0]            midiCmd,
    input  logic [NOTE_W-1:0]     midiData0,
    input  logic [VEL_W-1:0]      midiData1,
    output logic [NUM_VOICES-1:0] voicesBusy,
    noteIf.alloc                  voices [NUM_VOICES]
);

    midiCmdE cmdKind;
    logic isOn;
    logic isOff;

    logic [NUM_VOICES-1:0] busy;
    logic [NUM_VOICES-1:0] voiceActive;
    logic [NUM_VOICES-1:0] onHit;
    logic [NUM_VOICES-1:0] offHit;
    logic onFound;
    logic offFound;

    logic [NUM_VOICES-1:0] startStb;
    logic [NUM_VOICES-1:0] stopStb;
    logic [NOTE_W-1:0] noteReg;
    logic [VEL_W-1:0] velReg;
    logic [NOTE_W-1:0] heldNote [NUM_VOICES];

    // --------------------
    // Command decode
    // --------------------
    assign cmdKind = midiCmdE'(midiCmd);

    // Zero velocity note-on is a release
    assign isOn = midiValid && (cmdKind == CmdNoteOn) && (midiData1 != '0);
    assign isOff = midiValid && ((cmdKind == CmdNoteOff) ||
                                 ((cmdKind == CmdNoteOn) && (midiData1 == '0)));

    // Lowest free voice for a note-on, lowest holder for a note-off
    always_comb begin
        onHit = '0;
        offHit = '0;
        onFound = 1'b0;
        offFound = 1'b0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            // A voice still winding down from a stop is not yet free
            if (!onFound && !busy[i] && !voiceActive[i]) begin
                onHit[i] = 1'b1;
                onFound = 1'b1;
            end
            if (!offFound && busy[i] && (heldNote[i] == midiData0)) begin
                offHit[i] = 1'b1;
                offFound = 1'b1;
            end
        end
    end

    // --------------------
    // Hold table and strobes
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= '0;
            startStb <= '0;
            stopStb <= '0;
        end else begin
            startStb <= isOn ? onHit : '0;
            stopStb <= isOff ? offHit : '0;
            busy <= (busy | (isOn ? onHit : '0)) & ~(isOff ? offHit : '0);
        end
    end

    always_ff @(posedge clk) begin
        if (isOn) begin
            noteReg <= midiData0;
            velReg <= midiData1;
        end
        for (int i = 0; i < NUM_VOICES; i++) begin
            if (isOn && onHit[i]) begin
                heldNote[i] <= midiData0;
            end
        end
    end

    assign voicesBusy = busy;

    for (genvar i = 0; i < NUM_VOICES; i++) begin : genPort
        assign voices[i].start = startStb[i];
        assign voices[i].stop = stopStb[i];
        assign voices[i].note = noteReg;
        assign voices[i].velocity = velReg;
        assign voiceActive[i] = voices[i].active;
    end

endmodule

// ==== logic/triangleVoice.sv ====
// Single triangle voice with step lookup, reflecting accumulator
// and velocity scaling
`timescale 1ns/1ps

module triangleVoice
    import synthPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   sampleTick,
    noteIf.voice   cmd,
    output sampleT sample
);

    typedef enum logic {
        Idle,
        Playing
    } voiceStateE;

    voiceStateE state;
    sampleT step;
    sampleT value;
    logic dirUp;
    logic [VEL_W-1:0] vel;
    logic signed [SAMPLE_W+VEL_W-1:0] scaled;

    // --------------------
    // Voice state
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= Idle;
        end else if (cmd.start) begin
            state <= Playing;
        end else if (cmd.stop) begin
            state <= Idle;
        end
    end

    assign cmd.active = (state == Playing);

    // Phase step of the new note
    always_ff @(posedge clk) begin
        if (cmd.start) begin
            step <= sampleT'(noteStep(cmd.note));
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vel <= '0;
        end else if (cmd.start) begin
            vel <= cmd.velocity;
        end
    end

    // --------------------
    // Triangle accumulator
    // --------------------
    // Direction follows the value every cycle, so it has flipped
    // before the next tick arrives
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dirUp <= 1'b1;
        end else if (cmd.start) begin
            dirUp <= 1'b1;
        end else if (value >= TRI_LIMIT) begin
            dirUp <= 1'b0;
        end else if (value <= -TRI_LIMIT) begin
            dirUp <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            value <= '0;
        end else if (cmd.start || cmd.stop) begin
            value <= '0;
        end else if ((state == Playing) && sampleTick) begin
            value <= dirUp ? value + step : value - step;
        end
    end

    // Velocity scale, 127 is just under unity
    assign scaled = value * $signed({1'b0, vel});
    assign sample = scaled[SAMPLE_W+VEL_W-1:VEL_W];

endmodule

// ==== logic/voiceMixer.sv ====
// Voice summing mixer with saturation and registered output sample
`timescale 1ns/1ps

module voiceMixer
    import synthPkg::*;
#(
    parameter int NUM_VOICES = 4
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   sampleTick,
    input  sampleT voiceSamples [NUM_VOICES],
    output logic   sampleValid,
    output sampleT sampleOut
);

    // Headroom for the full sum of all voices
    localparam int SUM_W = SAMPLE_W + $clog2(NUM_VOICES + 1);

    localparam logic signed [SUM_W-1:0] SAT_HI = SUM_W'(131071);
    localparam logic signed [SUM_W-1:0] SAT_LO = -SUM_W'(131072);

    logic signed [SUM_W-1:0] sum;
    sampleT satSample;

    always_comb begin
        sum = '0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            sum = sum + voiceSamples[i];
        end
    end

    // Clamp to the 18-bit range
    always_comb begin
        if (sum > SAT_HI) begin
            satSample = SAT_HI[SAMPLE_W-1:0];
        end else if (sum < SAT_LO) begin
            satSample = SAT_LO[SAMPLE_W-1:0];
        end else begin
            satSample = sum[SAMPLE_W-1:0];
        end
    end

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sampleValid <= 1'b0;
            sampleOut <= '0;
        end else begin
            sampleValid <= sampleTick;
            if (sampleTick) begin
                sampleOut <= satSample;
            end
        end
    end

endmodule

// ==== logic/triangleSynth.sv ====
// Polyphonic triangle synthesizer top level with allocator,
// voice array and mixer
`timescale 1ns/1ps

module triangleSynth
    import synthPkg::*;
#(
    parameter int NUM_VOICES = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  midiValid,
    input  logic [3:0]            midiCmd,
    input  logic [NOTE_W-1:0]     midiData0,
    input  logic [VEL_W-1:0]      midiData1,
    input  logic                  sampleTick,
    output logic                  sampleValid,
    output sampleT                sampleOut,
    output logic [NUM_VOICES-1:0] voicesBusy
);

    noteIf voiceCmd [NUM_VOICES] ();
    sampleT voiceSamples [NUM_VOICES];

    midiVoiceAlloc #(
        .NUM_VOICES (NUM_VOICES)
    ) alloc_i (
        .clk        (clk),
        .reset      (reset),
        .midiValid  (midiValid),
        .midiCmd    (midiCmd),
        .midiData0  (midiData0),
        .midiData1  (midiData1),
        .voicesBusy (voicesBusy),
        .voices     (voiceCmd)
    );

    for (genvar v = 0; v < NUM_VOICES; v++) begin : genVoice
        triangleVoice voice_i (
            .clk        (clk),
            .reset      (reset),
            .sampleTick (sampleTick),
            .cmd        (voiceCmd[v]),
            .sample     (voiceSamples[v])
        );
    end

    voiceMixer #(
        .NUM_VOICES (NUM_VOICES)
    ) mixer_i (
        .clk          (clk),
        .reset        (reset),
        .sampleTick   (sampleTick),
        .voiceSamples (voiceSamples),
        .sampleValid  (sampleValid),
        .sampleOut    (sampleOut)
    );

endmodule

// ==== bench/triangleSynth_assert.sv ====
// Bound checks on the sample valid timing of the synthesizer
`timescale 1ns/1ps

module triangleSynth_assert (
    input logic clk,
    input logic reset,
    input logic sampleTick,
    input logic sampleValid
);

    // --------------------
    // Sample valid rules
    // --------------------
    // One cycle pulse per sample
    validSingle: assert property (
        @(posedge clk) disable iff (reset) sampleValid |=> !sampleValid
    ) else $error("sampleValid stayed high for two cycles");

    // Tick leads valid by exactly one cycle
    validAfterTick: assert property (
        @(posedge clk) disable iff (reset) sampleTick |=> sampleValid
    ) else $error("sampleValid missing one cycle after sampleTick");

    validNeedsTick: assert property (
        @(posedge clk) disable iff (reset) sampleValid |-> $past(sampleTick)
    ) else $error("sampleValid without a sampleTick one cycle before");

endmodule

bind triangleSynth triangleSynth_assert assert_i (
    .clk         (clk),
    .reset       (reset),
    .sampleTick  (sampleTick),
    .sampleValid (sampleValid)
);

// ==== bench/triangleSynthTb.sv ====
// Testbench for the triangle synthesizer with stimulus table,
// voice model, compare tasks and cycle guard
`timescale 1ns/1ps

module triangleSynthTb
    import synthPkg::*;
();

    localparam int NUM_VOICES = 4;
    localparam int NUM_ROWS = 18;

    typedef struct {
        logic [3:0]            cmd;
        logic [NOTE_W-1:0]     note;
        logic [VEL_W-1:0]      vel;
        int                    ticks;
        logic [NUM_VOICES-1:0] busy;
    } rowT;

    logic clk;
    logic reset;
    logic midiValid;
    logic [3:0] midiCmd;
    logic [NOTE_W-1:0] midiData0;
    logic [VEL_W-1:0] midiData1;
    logic sampleTick;
    logic sampleValid;
    sampleT sampleOut;
    logic [NUM_VOICES-1:0] voicesBusy;

    rowT rows [NUM_ROWS];
    sampleT expectQ [$];
    int errorCount = 0;
    int checkCount = 0;
    int cycles = 0;
    int timeoutLimit = 0;

    // Model of each voice
    bit mBusy [NUM_VOICES];
    logic [NOTE_W-1:0] mNote [NUM_VOICES];
    int mVal [NUM_VOICES];
    int mStep [NUM_VOICES];
    int mVel [NUM_VOICES];
    bit mUp [NUM_VOICES];

    triangleSynth #(
        .NUM_VOICES (NUM_VOICES)
    ) dut_i (
        .clk         (clk),
        .reset       (reset),
        .midiValid   (midiValid),
        .midiCmd     (midiCmd),
        .midiData0   (midiData0),
        .midiData1   (midiData1),
        .sampleTick  (sampleTick),
        .sampleValid (sampleValid),
        .sampleOut   (sampleOut),
        .voicesBusy  (voicesBusy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (timeoutLimit > 0 && cycles >= timeoutLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
            $display("Test failures found");
            $finish;
        end
    end

    // --------------------
    // Reference model
    // --------------------
    // Octave 0 step per semitone, doubled per octave, capped at note 99
    function automatic int refStep(input int note);
        int base [12] = '{'h59, 'h5E, 'h64, 'h6A, 'h70, 'h77,
                          'h7E, 'h85, 'h8D, 'h96, 'h9F, 'hA8};
        int n;
        n = (note > 99) ? 99 : note;
        return base[n % 12] << (n / 12);
    endfunction

    task automatic modelCommand(input rowT r);
        int hit;
        hit = -1;
        if (r.cmd == CmdNoteOn && r.vel != '0) begin
            for (int i = NUM_VOICES - 1; i >= 0; i--) begin
                if (!mBusy[i]) hit = i;
            end
            if (hit >= 0) begin
                mBusy[hit] = 1'b1;
                mNote[hit] = r.note;
                mVal[hit] = 0;
                mStep[hit] = refStep(int'(r.note));
                mVel[hit] = int'(r.vel);
                mUp[hit] = 1'b1;
            end
        end else if (r.cmd == CmdNoteOff || r.cmd == CmdNoteOn) begin
            for (int i = NUM_VOICES - 1; i >= 0; i--) begin
                if (mBusy[i] && mNote[i] == r.note) hit = i;
            end
            if (hit >= 0) begin
                mBusy[hit] = 1'b0;
                mVal[hit] = 0;
            end
        end
    endtask

    // Sample seen at this tick, then advance every playing voice
    task automatic modelTick(output sampleT expected);
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            sum += (mVal[i] * mVel[i]) >>> 7;
        end
        for (int i = 0; i < NUM_VOICES; i++) begin
            if (mBusy[i]) begin
                mVal[i] = mUp[i] ? mVal[i] + mStep[i] : mVal[i] - mStep[i];
                if (mVal[i] >= TRI_LIMIT) mUp[i] = 1'b0;
                else if (mVal[i] <= -TRI_LIMIT) mUp[i] = 1'b1;
            end
        end
        if (sum > 131071) sum = 131071;
        else if (sum < -131072) sum = -131072;
        expected = sampleT'(sum);
    endtask

    // --------------------
    // Compare tasks
    // --------------------
    task automatic checkSample(input sampleT got, input sampleT expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("Error: sampleOut is 0x%05h, expected 0x%05h", got, expected);
        end
    endtask

    task automatic checkBusy(input logic [NUM_VOICES-1:0] got,
                             input logic [NUM_VOICES-1:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("Error: voicesBusy is 0x%0h, expected 0x%0h", got, expected);
        end
    endtask

    always @(negedge clk) begin
        if (!reset && sampleValid) begin
            if (expectQ.size() == 0) begin
                errorCount++;
                $display("sampleValid went high with no sample tick pending");
            end else begin
                checkSample(sampleOut, expectQ.pop_front());
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    task automatic setRow(input int idx, input logic [3:0] cmd, input int note,
                          input int vel, input int ticks,
                          input logic [NUM_VOICES-1:0] busy);
        rows[idx].cmd = cmd;
        rows[idx].note = NOTE_W'(note);
        rows[idx].vel = VEL_W'(vel);
        rows[idx].ticks = ticks;
        rows[idx].busy = busy;
    endtask

    // Nonzero so it never turns into a release
    function automatic int fillerVel();
        return 1 + int'($urandom % 127);
    endfunction

    task automatic loadTable();
        setRow(0, 4'h0, 0, 0, 3, 4'b0000);
        setRow(1, CmdNoteOn, 60, 127, 30, 4'b0001);
        setRow(2, CmdNoteOn, 72, fillerVel(), 6, 4'b0011);
        setRow(3, CmdNoteOn, 84, fillerVel(), 6, 4'b0111);
        setRow(4, CmdNoteOn, 96, 127, 10, 4'b1111);
        // All voices busy, dropped
        setRow(5, CmdNoteOn, 50, 100, 4, 4'b1111);
        setRow(6, CmdNoteOff, 72, 64, 4, 4'b1101);
        setRow(7, CmdNoteOff, 61, 64, 2, 4'b1101);
        setRow(8, CmdNoteOn, 84, 0, 4, 4'b1001);
        setRow(9, 4'hA, 60, 50, 2, 4'b1001);
        setRow(10, CmdNoteOn, 120, 90, 8, 4'b1011);
        setRow(11, CmdNoteOff, 60, 0, 4, 4'b1010);
        setRow(12, CmdNoteOn, 60, fillerVel(), 6, 4'b1011);
        setRow(13, CmdNoteOn, 60, fillerVel(), 4, 4'b1111);
        setRow(14, CmdNoteOff, 60, 0, 4, 4'b1110);
        setRow(15, CmdNoteOff, 96, 0, 3, 4'b0110);
        setRow(16, CmdNoteOff, 120, 0, 3, 4'b0100);
        setRow(17, CmdNoteOff, 60, 0, 3, 4'b0000);
    endtask

    task automatic sendCommand(input rowT r);
        @(posedge clk);
        midiValid <= 1'b1;
        midiCmd <= r.cmd;
        midiData0 <= r.note;
        midiData1 <= r.vel;
        @(posedge clk);
        midiValid <= 1'b0;
        @(negedge clk);
        checkBusy(voicesBusy, r.busy);
        modelCommand(r);
        @(posedge clk);
    endtask

    task automatic issueTick();
        sampleT expected;
        @(posedge clk);
        sampleTick <= 1'b1;
        modelTick(expected);
        expectQ.push_back(expected);
        @(posedge clk);
        sampleTick <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        int rowErrors;
        int passRows;
        int failRows;
        reset = 1'b1;
        midiValid = 1'b0;
        midiCmd = '0;
        midiData0 = '0;
        midiData1 = '0;
        sampleTick = 1'b0;
        passRows = 0;
        failRows = 0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            mBusy[i] = 1'b0;
            mNote[i] = '0;
            mVal[i] = 0;
            mStep[i] = 0;
            mVel[i] = 0;
            mUp[i] = 1'b1;
        end
        void'($urandom(9));
        loadTable();
        for (int r = 0; r < NUM_ROWS; r++) begin
            timeoutLimit += rows[r].ticks * 3 + 4;
        end
        timeoutLimit += 100;

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkBusy(voicesBusy, '0);
        checkSample(sampleOut, '0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            rowErrors = errorCount;
            sendCommand(rows[r]);
            for (int k = 0; k < rows[r].ticks; k++) begin
                issueTick();
            end
            if (errorCount == rowErrors) begin
                passRows++;
                $display("Row %0d cmd 0x%0h note %0d vel %0d: ok",
                         r, rows[r].cmd, rows[r].note, rows[r].vel);
            end else begin
                failRows++;
                $display("Row %0d cmd 0x%0h note %0d vel %0d: %0d errors",
                         r, rows[r].cmd, rows[r].note, rows[r].vel, errorCount - rowErrors);
            end
        end

        if (expectQ.size() != 0) begin
            errorCount++;
            $display("%0d expected samples never appeared", expectQ.size());
        end
        $display("Done: %0d rows ok, %0d rows failed, %0d checks, %0d errors",
                 passRows, failRows, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== build.f ====
logic/synthPkg.sv
logic/noteIf.sv
logic/midiVoiceAlloc.sv
logic/triangleVoice.sv
logic/voiceMixer.sv
logic/triangleSynth.sv
bench/triangleSynth_assert.sv
bench/triangleSynthTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = triangleSynthTb
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
